// File: files.f
+incdir+include
hdl/ex_pkg.sv
hdl/ex_alu.sv
hdl/ex_branch_unit.sv
hdl/ex_csr_buffer.sv
hdl/ex_mult.sv
hdl/ex_writeback.sv
hdl/ex_stage.sv
test/tb_ex_stage.sv

// File: hdl/ex_alu.sv
/*
 * ALU of the execute stage
 * Single-cycle arithmetic, logic, shift and compare operations,
 * plus the comparison bit used by the branch unit
 */

`include "ex_settings.svh"

module ex_alu (
  input  logic                alu_valid_i,
  input  logic                branch_valid_i,
  input  ex_pkg::fu_op_e      operation_i,
  input  logic [`EX_XLEN-1:0] operand_a_i,
  input  logic [`EX_XLEN-1:0] operand_b_i,
  output logic [`EX_XLEN-1:0] result_o,
  output logic                cmp_res_o
);

  // ----------------------------------------------------------------------
  // Operand silencing
  // ----------------------------------------------------------------------
  logic                active;
  logic [`EX_XLEN-1:0] op_a;
  logic [`EX_XLEN-1:0] op_b;
  logic [4:0]          shamt;
  logic                eq;
  logic                lt_s;
  logic                lt_u;

  // Branches also need the comparator
  assign active = alu_valid_i | branch_valid_i;
  assign op_a   = active ? operand_a_i : '0;
  assign op_b   = active ? operand_b_i : '0;

  // Only the low five bits count for a 32 bit shift
  assign shamt = op_b[4:0];

  // Shared comparator
  assign eq   = (op_a == op_b);
  assign lt_s = ($signed(op_a) < $signed(op_b));
  assign lt_u = (op_a < op_b);

  // ----------------------------------------------------------------------
  // Result select
  // ----------------------------------------------------------------------
  always_comb begin
    result_o = '0;
    case (operation_i)
      ex_pkg::ADD:  result_o = op_a + op_b;
      ex_pkg::SUB:  result_o = op_a - op_b;
      ex_pkg::AND:  result_o = op_a & op_b;
      ex_pkg::OR:   result_o = op_a | op_b;
      ex_pkg::XOR:  result_o = op_a ^ op_b;
      ex_pkg::SLL:  result_o = op_a << shamt;
      ex_pkg::SRL:  result_o = op_a >> shamt;
      // Sign bit replicated from the top
      ex_pkg::SRA:  result_o = $signed(op_a) >>> shamt;
      ex_pkg::SLT:  result_o = {{(`EX_XLEN-1){1'b0}}, lt_s};
      ex_pkg::SLTU: result_o = {{(`EX_XLEN-1){1'b0}}, lt_u};
      default:      result_o = '0;
    endcase
  end

  // ----------------------------------------------------------------------
  // Branch comparison bit
  // ----------------------------------------------------------------------
  always_comb begin
    cmp_res_o = 1'b0;
    case (operation_i)
      ex_pkg::EQ:  cmp_res_o = eq;
      ex_pkg::NE:  cmp_res_o = ~eq;
      ex_pkg::LTS: cmp_res_o = lt_s;
      ex_pkg::GES: cmp_res_o = ~lt_s;
      ex_pkg::LTU: cmp_res_o = lt_u;
      ex_pkg::GEU: cmp_res_o = ~lt_u;
      // Not a branch, never taken
      default:     cmp_res_o = 1'b0;
    endcase
  end

endmodule

// File: hdl/ex_branch_unit.sv
/*
 * Branch unit
 * Resolves conditional branches against the fetch prediction and
 * produces the link address for the write-back port
 */

`include "ex_settings.svh"

module ex_branch_unit (
  input  logic                branch_valid_i,
  input  ex_pkg::fu_op_e      operation_i,
  input  logic                cmp_res_i,
  input  logic [`EX_XLEN-1:0] pc_i,
  input  logic [`EX_XLEN-1:0] imm_i,
  input  logic                is_compressed_i,
  input  logic                predict_taken_i,
  input  logic [`EX_XLEN-1:0] predict_target_i,
  output logic [`EX_XLEN-1:0] link_o,
  output logic                resolve_o,
  output logic                taken_o,
  output logic [`EX_XLEN-1:0] target_o,
  output logic                mispredict_o
);

  // Bundle comes in unsilenced, this path is already timing critical
  logic [`EX_XLEN-1:0] target;
  logic [`EX_XLEN-1:0] step;
  logic                is_branch;
  logic                dir_wrong;
  logic                tgt_wrong;

  // Only the six conditions resolve a branch
  always_comb begin
    case (operation_i)
      ex_pkg::EQ, ex_pkg::NE, ex_pkg::LTS,
      ex_pkg::GES, ex_pkg::LTU, ex_pkg::GEU: is_branch = 1'b1;
      default:                               is_branch = 1'b0;
    endcase
  end

  // ----------------------------------------------------------------------
  // Target and link
  // ----------------------------------------------------------------------
  assign target = pc_i + imm_i;

  // Next sequential PC depends on instruction size
  assign step   = is_compressed_i ? `EX_XLEN'(`EX_PC_STEP_C) : `EX_XLEN'(`EX_PC_STEP);
  assign link_o = pc_i + step;

  assign target_o = target;
  assign taken_o  = cmp_res_i;

  // ----------------------------------------------------------------------
  // Resolution
  // ----------------------------------------------------------------------
  assign resolve_o = branch_valid_i & is_branch;

  // Wrong direction, or taken to the wrong place
  assign dir_wrong    = (predict_taken_i != cmp_res_i);
  assign tgt_wrong    = cmp_res_i & (predict_target_i != target);
  assign mispredict_o = resolve_o & (dir_wrong | tgt_wrong);

  // Every issued branch carries one of the six conditions
  always_comb begin
    if (branch_valid_i) begin
      assert (resolve_o)
        else $error("branch issued with a non-branch operation");
    end
  end

endmodule

// File: hdl/ex_csr_buffer.sv
/*
 * CSR buffer
 * Holds one CSR address until the instruction commits and blocks
 * further issue while the entry is occupied
 */

`include "ex_settings.svh"

module ex_csr_buffer (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         flush_i,
  input  logic                         csr_valid_i,
  input  logic                         csr_commit_i,
  input  logic [`EX_XLEN-1:0]          operand_a_i,
  input  logic [`EX_XLEN-1:0]          imm_i,
  output logic                         csr_ready_o,
  output logic [`EX_XLEN-1:0]          csr_result_o,
  output logic [`EX_CSR_ADDR_BITS-1:0] csr_addr_o
);

  logic                         full_q;
  logic [`EX_CSR_ADDR_BITS-1:0] addr_q;

  // Value to write into the CSR, silenced when idle
  assign csr_result_o = csr_valid_i ? operand_a_i : '0;

  assign csr_ready_o = ~full_q;
  assign csr_addr_o  = addr_q;

  // ----------------------------------------------------------------------
  // Occupancy
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      full_q <= 1'b0;
    end else if (flush_i || csr_commit_i) begin
      // Entry retired or squashed
      full_q <= 1'b0;
    end else if (csr_valid_i) begin
      full_q <= 1'b1;
    end
  end

  // Address field sits in the low immediate bits
  always_ff @(posedge clk_i) begin
    if (csr_valid_i) begin
      addr_q <= imm_i[`EX_CSR_ADDR_BITS-1:0];
    end
  end

  // Issue logic must wait for ready before a second CSR op
  assert property (@(posedge clk_i) disable iff (!rst_ni) full_q |-> !csr_valid_i)
    else $error("CSR issued while buffer full");

endmodule

// File: hdl/ex_mult.sv
/*
 * Multiplier
 * Fixed one-cycle latency, fully pipelined, the transaction ID
 * travels alongside the product
 */

`include "ex_settings.svh"

module ex_mult (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         flush_i,
  input  logic                         mult_valid_i,
  input  ex_pkg::fu_op_e               operation_i,
  input  logic [`EX_XLEN-1:0]          operand_a_i,
  input  logic [`EX_XLEN-1:0]          operand_b_i,
  input  logic [`EX_TRANS_ID_BITS-1:0] trans_id_i,
  output logic                         mult_valid_o,
  output logic [`EX_XLEN-1:0]          result_o,
  output logic [`EX_TRANS_ID_BITS-1:0] trans_id_o
);

  logic [`EX_XLEN-1:0]          op_a;
  logic [`EX_XLEN-1:0]          op_b;
  logic [`EX_TRANS_ID_BITS-1:0] id_g;
  logic signed [2*`EX_XLEN-1:0] prod_s;
  logic [2*`EX_XLEN-1:0]        prod_u;
  logic [`EX_XLEN-1:0]          result_d;
  logic                         valid_q;
  logic [`EX_XLEN-1:0]          result_q;
  logic [`EX_TRANS_ID_BITS-1:0] trans_id_q;

  // Inputs silenced when not issued
  assign op_a = mult_valid_i ? operand_a_i : '0;
  assign op_b = mult_valid_i ? operand_b_i : '0;
  assign id_g = mult_valid_i ? trans_id_i : '0;

  // ----------------------------------------------------------------------
  // Full width products
  // ----------------------------------------------------------------------
  assign prod_s = $signed(op_a) * $signed(op_b);
  assign prod_u = op_a * op_b;

  // Word select
  always_comb begin
    case (operation_i)
      ex_pkg::MUL:   result_d = prod_u[`EX_XLEN-1:0];
      ex_pkg::MULH:  result_d = prod_s[2*`EX_XLEN-1:`EX_XLEN];
      ex_pkg::MULHU: result_d = prod_u[2*`EX_XLEN-1:`EX_XLEN];
      default:       result_d = '0;
    endcase
  end

  // ----------------------------------------------------------------------
  // Output stage
  // ----------------------------------------------------------------------
  // Flush kills whatever would land next cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (flush_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= mult_valid_i;
    end
  end

  // New product every cycle, back-to-back issue allowed
  always_ff @(posedge clk_i) begin
    result_q   <= result_d;
    trans_id_q <= id_g;
  end

  assign mult_valid_o = valid_q;
  assign result_o     = result_q;
  assign trans_id_o   = trans_id_q;

endmodule

// File: hdl/ex_pkg.sv
/*
 * Execute stage package
 * Operation encoding shared by the issue port and all functional units
 */

package ex_pkg;

  // --------------------------------------------------------------------
  // Functional unit operations
  // --------------------------------------------------------------------
  // One encoding space for all units, the strobe picks the unit
  typedef enum logic [4:0] {
    // ALU arithmetic and logic
    ADD    = 5'd0,
    SUB    = 5'd1,
    AND    = 5'd2,
    OR     = 5'd3,
    XOR    = 5'd4,
    // ALU shifts
    SLL    = 5'd5,
    SRL    = 5'd6,
    SRA    = 5'd7,
    // ALU set-less-than
    SLT    = 5'd8,
    SLTU   = 5'd9,
    // Branch conditions, evaluated by the ALU comparator
    EQ     = 5'd10,
    NE     = 5'd11,
    LTS    = 5'd12,
    GES    = 5'd13,
    LTU    = 5'd14,
    GEU    = 5'd15,
    // CSR access through the buffer
    CSR_RW = 5'd16,
    // Multiplier
    MUL    = 5'd17,
    MULH   = 5'd18,
    MULHU  = 5'd19
  } fu_op_e;

endpackage

// File: hdl/ex_stage.sv
/*
 * Execute stage top level
 * Fixed-latency units behind one issue port and one write-back port
 */

`include "ex_settings.svh"

module ex_stage (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         flush_i,
  // Issue bundle
  input  ex_pkg::fu_op_e               operation_i,
  input  logic [`EX_XLEN-1:0]          operand_a_i,
  input  logic [`EX_XLEN-1:0]          operand_b_i,
  input  logic [`EX_XLEN-1:0]          imm_i,
  input  logic [`EX_XLEN-1:0]          pc_i,
  input  logic                         is_compressed_i,
  input  logic [`EX_TRANS_ID_BITS-1:0] trans_id_i,
  // Unit strobes, at most one per cycle
  input  logic                         alu_valid_i,
  input  logic                         branch_valid_i,
  input  logic                         csr_valid_i,
  input  logic                         mult_valid_i,
  // Prediction from fetch
  input  logic                         predict_taken_i,
  input  logic [`EX_XLEN-1:0]          predict_target_i,
  input  logic                         csr_commit_i,
  // Shared write-back port
  output logic                         flu_valid_o,
  output logic [`EX_XLEN-1:0]          flu_result_o,
  output logic [`EX_TRANS_ID_BITS-1:0] flu_trans_id_o,
  output logic                         flu_ready_o,
  output logic [`EX_CSR_ADDR_BITS-1:0] csr_addr_o,
  // Branch resolution
  output logic                         resolve_o,
  output logic                         taken_o,
  output logic [`EX_XLEN-1:0]          target_o,
  output logic                         mispredict_o
);

  // ----------------------------------------------------------------------
  // Internal wires
  // ----------------------------------------------------------------------
  logic                         cmp_res;
  logic [`EX_XLEN-1:0]          alu_result;
  logic [`EX_XLEN-1:0]          link;
  logic [`EX_XLEN-1:0]          csr_result;
  logic                         mult_valid;
  logic [`EX_XLEN-1:0]          mult_result;
  logic [`EX_TRANS_ID_BITS-1:0] mult_trans_id;

  // ALU, also the branch comparator
  ex_alu alu_inst (
    .alu_valid_i   (alu_valid_i),
    .branch_valid_i(branch_valid_i),
    .operation_i   (operation_i),
    .operand_a_i   (operand_a_i),
    .operand_b_i   (operand_b_i),
    .result_o      (alu_result),
    .cmp_res_o     (cmp_res)
  );

  // Branch unit
  ex_branch_unit branch_unit_inst (
    .branch_valid_i  (branch_valid_i),
    .operation_i     (operation_i),
    .cmp_res_i       (cmp_res),
    .pc_i            (pc_i),
    .imm_i           (imm_i),
    .is_compressed_i (is_compressed_i),
    .predict_taken_i (predict_taken_i),
    .predict_target_i(predict_target_i),
    .link_o          (link),
    .resolve_o       (resolve_o),
    .taken_o         (taken_o),
    .target_o        (target_o),
    .mispredict_o    (mispredict_o)
  );

  // CSR buffer, its ready is the whole FLU ready
  ex_csr_buffer csr_buffer_inst (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .flush_i     (flush_i),
    .csr_valid_i (csr_valid_i),
    .csr_commit_i(csr_commit_i),
    .operand_a_i (operand_a_i),
    .imm_i       (imm_i),
    .csr_ready_o (flu_ready_o),
    .csr_result_o(csr_result),
    .csr_addr_o  (csr_addr_o)
  );

  // Multiplier
  ex_mult mult_inst (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .flush_i     (flush_i),
    .mult_valid_i(mult_valid_i),
    .operation_i (operation_i),
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .trans_id_i  (trans_id_i),
    .mult_valid_o(mult_valid),
    .result_o    (mult_result),
    .trans_id_o  (mult_trans_id)
  );

  // Write-back select
  ex_writeback writeback_inst (
    .alu_valid_i    (alu_valid_i),
    .csr_valid_i    (csr_valid_i),
    .branch_valid_i (branch_valid_i),
    .mult_valid_i   (mult_valid),
    .alu_result_i   (alu_result),
    .csr_result_i   (csr_result),
    .mult_result_i  (mult_result),
    .link_i         (link),
    .trans_id_i     (trans_id_i),
    .mult_trans_id_i(mult_trans_id),
    .flu_valid_o    (flu_valid_o),
    .flu_result_o   (flu_result_o),
    .flu_trans_id_o (flu_trans_id_o)
  );

endmodule

// File: hdl/ex_writeback.sv
/*
 * Write-back select
 * Picks result, transaction ID and valid of the shared FLU port
 */

`include "ex_settings.svh"

module ex_writeback (
  input  logic                         alu_valid_i,
  input  logic                         csr_valid_i,
  input  logic                         branch_valid_i,
  input  logic                         mult_valid_i,
  input  logic [`EX_XLEN-1:0]          alu_result_i,
  input  logic [`EX_XLEN-1:0]          csr_result_i,
  input  logic [`EX_XLEN-1:0]          mult_result_i,
  input  logic [`EX_XLEN-1:0]          link_i,
  input  logic [`EX_TRANS_ID_BITS-1:0] trans_id_i,
  input  logic [`EX_TRANS_ID_BITS-1:0] mult_trans_id_i,
  output logic                         flu_valid_o,
  output logic [`EX_XLEN-1:0]          flu_result_o,
  output logic [`EX_TRANS_ID_BITS-1:0] flu_trans_id_o
);

  // One writer per cycle on the scoreboard port
  assign flu_valid_o = alu_valid_i | branch_valid_i | csr_valid_i | mult_valid_i;

  // ----------------------------------------------------------------------
  // Result mux
  // ----------------------------------------------------------------------
  always_comb begin
    // Branch link by default
    flu_result_o   = link_i;
    flu_trans_id_o = trans_id_i;
    if (alu_valid_i) begin
      flu_result_o = alu_result_i;
    end else if (csr_valid_i) begin
      flu_result_o = csr_result_i;
    end else if (mult_valid_i) begin
      // Product belongs to an earlier issue
      flu_result_o   = mult_result_i;
      flu_trans_id_o = mult_trans_id_i;
    end
  end

  // Cycle after a multiply is reserved for its result
  always_comb begin
    if (mult_valid_i) begin
      assert (!(alu_valid_i || branch_valid_i || csr_valid_i))
        else $error("multiplier result collides with a new issue");
    end
  end

endmodule

// File: include/ex_settings.svh
/*
 * Execute stage settings
 * Widths and PC step sizes shared by every unit of the execute stage
 */

`ifndef EX_SETTINGS_SVH
`define EX_SETTINGS_SVH

// ----------------------------------------------------------------------
// Datapath widths
// ----------------------------------------------------------------------

// Operands, results and PC
`define EX_XLEN 32

// Scoreboard entry index
`define EX_TRANS_ID_BITS 3

// CSR address field of the instruction
`define EX_CSR_ADDR_BITS 12

// ----------------------------------------------------------------------
// Link address increments
// ----------------------------------------------------------------------

// Full size instruction
`define EX_PC_STEP 4
// Compressed instruction
`define EX_PC_STEP_C 2

`endif

// File: run.sh
#!/bin/sh
# Build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module tb_ex_stage -f files.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/Vtb_ex_stage)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

# Verdict comes from the testbench output
if printf '%s\n' "$output" | grep -qx '>>> PASS'; then
  exit 0
fi
exit 1

// File: test/ex_testdata.txt
# strb(mul,csr,br,alu) op a b imm pc cmp tid ptaken ptarget ctl(flush,commit)
# valid result tid flags(ready,resolve,mispredict,taken) target csr_addr skip(addr,br,tid,res)
# Reset state
0 00 00000000 00000000 00000000 00000000 0 0 0 00000000 0  0 00000000 0 8 00000000 000 b
# ALU
1 00 00000005 00000007 00000000 00000000 0 1 0 00000000 0  1 0000000c 1 8 00000000 000 8
1 00 ffffffff 00000002 00000000 00000000 0 2 0 00000000 0  1 00000001 2 8 00000000 000 8
1 01 00000003 00000005 00000000 00000000 0 3 0 00000000 0  1 fffffffe 3 8 00000000 000 8
1 02 f0f0a5a5 0ff05a5f 00000000 00000000 0 4 0 00000000 0  1 00f00005 4 8 00000000 000 8
1 03 f0f0a5a5 0ff05a5f 00000000 00000000 0 5 0 00000000 0  1 fff0ffff 5 8 00000000 000 8
1 04 f0f0a5a5 0ff05a5f 00000000 00000000 0 6 0 00000000 0  1 ff00fffa 6 8 00000000 000 8
1 05 00000081 00000024 00000000 00000000 0 7 0 00000000 0  1 00000810 7 8 00000000 000 8
1 06 80000010 00000004 00000000 00000000 0 0 0 00000000 0  1 08000001 0 8 00000000 000 8
1 07 80000010 00000004 00000000 00000000 0 1 0 00000000 0  1 f8000001 1 8 00000000 000 8
1 07 40000000 0000003e 00000000 00000000 0 2 0 00000000 0  1 00000001 2 8 00000000 000 8
1 08 ffffffff 00000001 00000000 00000000 0 3 0 00000000 0  1 00000001 3 8 00000000 000 8
1 09 ffffffff 00000001 00000000 00000000 0 4 0 00000000 0  1 00000000 4 8 00000000 000 8
1 08 00000001 ffffffff 00000000 00000000 0 5 0 00000000 0  1 00000000 5 8 00000000 000 8
1 09 00000001 ffffffff 00000000 00000000 0 6 0 00000000 0  1 00000001 6 8 00000000 000 8
# Branches
2 0a 00000005 00000005 00000040 00001000 0 1 1 00001040 0  1 00001004 1 d 00001040 000 8
2 0b 00000005 00000005 00000040 00001000 1 2 0 00000000 0  1 00001002 2 c 00001040 000 8
2 0c fffffff0 00000001 fffffff8 00002000 0 3 0 00000000 0  1 00002004 3 f 00001ff8 000 8
2 0d fffffff0 00000001 fffffff8 00002000 0 4 1 00001ff8 0  1 00002004 4 e 00001ff8 000 8
2 0e fffffff0 00000001 00000010 00000100 1 5 0 00000000 0  1 00000102 5 c 00000110 000 8
2 0f fffffff0 00000001 00000010 00000100 0 6 1 00000114 0  1 00000104 6 f 00000110 000 8
2 0e 00000001 fffffff0 00000010 00000100 0 7 1 00000110 0  1 00000104 7 d 00000110 000 8
2 0a 00000001 00000002 00000800 00003000 0 0 1 00000000 0  1 00003004 0 e 00003800 000 8
# CSR buffer, released by commit and then by flush
4 10 deadbeef 00000000 00000341 00000000 0 3 0 00000000 0  1 deadbeef 3 8 00000341 000 8
1 00 00000001 00000001 00000000 00000000 0 4 0 00000000 0  1 00000002 4 0 00000000 341 0
0 00 00000000 00000000 00000000 00000000 0 0 0 00000000 0  0 00000000 0 0 00000000 341 3
0 00 00000000 00000000 00000000 00000000 0 0 0 00000000 1  0 00000000 0 0 00000000 341 3
0 00 00000000 00000000 00000000 00000000 0 0 0 00000000 0  0 00000000 0 8 00000000 341 3
4 10 12345678 00000000 0000a305 00000000 0 5 0 00000000 0  1 12345678 5 8 0000a305 341 0
0 00 00000000 00000000 00000000 00000000 0 0 0 00000000 2  0 00000000 0 0 00000000 305 3
0 00 00000000 00000000 00000000 00000000 0 0 0 00000000 0  0 00000000 0 8 00000000 305 3
# Multiplier, back-to-back issue
8 11 00000007 00000006 00000000 00000000 0 1 0 00000000 0  0 00000000 0 8 00000000 305 3
8 12 ffffffff 00000002 00000000 00000000 0 2 0 00000000 0  1 0000002a 1 8 00000000 305 0
8 13 ffffffff 00000002 00000000 00000000 0 3 0 00000000 0  1 ffffffff 2 8 00000000 305 0
0 00 00000000 00000000 00000000 00000000 0 0 0 00000000 0  1 00000001 3 8 00000000 305 0
0 00 00000000 00000000 00000000 00000000 0 0 0 00000000 0  0 00000000 0 8 00000000 305 3
8 12 ffffffff ffffffff 00000000 00000000 0 4 0 00000000 0  0 00000000 0 8 00000000 305 3
8 13 ffffffff ffffffff 00000000 00000000 0 5 0 00000000 0  1 00000000 4 8 00000000 305 0
8 11 12345678 00000010 00000000 00000000 0 6 0 00000000 0  1 fffffffe 5 8 00000000 305 0
0 00 00000000 00000000 00000000 00000000 0 0 0 00000000 0  1 23456780 6 8 00000000 305 0
# Flush in the cycle after a multiply
8 11 00000003 00000009 00000000 00000000 0 7 0 00000000 0  0 00000000 0 8 00000000 305 3
0 00 00000000 00000000 00000000 00000000 0 0 0 00000000 2  1 0000001b 7 8 00000000 305 0
0 00 00000000 00000000 00000000 00000000 0 0 0 00000000 0  0 00000000 0 8 00000000 305 3
1 01 00000000 00000001 00000000 00000000 0 1 0 00000000 0  1 ffffffff 1 8 00000000 305 0

// File: test/tb_ex_stage.sv
/*
 * Testbench for the execute stage
 * Replays vectors from the data file, one per clock cycle, and compares
 * the write-back, branch and CSR outputs with their expected values
 */

`include "ex_settings.svh"

module tb_ex_stage;

  localparam string DATA_FILE  = "test/ex_testdata.txt";
  localparam int    NUM_FIELDS = 18;

  // One line of the data file, columns in file order
  typedef struct packed {
    logic [3:0]                   strb;
    logic [4:0]                   op;
    logic [`EX_XLEN-1:0]          a;
    logic [`EX_XLEN-1:0]          b;
    logic [`EX_XLEN-1:0]          imm;
    logic [`EX_XLEN-1:0]          pc;
    logic                         comp;
    logic [`EX_TRANS_ID_BITS-1:0] tid;
    logic                         ptaken;
    logic [`EX_XLEN-1:0]          ptarget;
    logic [3:0]                   ctl;
    logic                         exp_valid;
    logic [`EX_XLEN-1:0]          exp_result;
    logic [`EX_TRANS_ID_BITS-1:0] exp_tid;
    logic [3:0]                   exp_flags;
    logic [`EX_XLEN-1:0]          exp_target;
    logic [`EX_CSR_ADDR_BITS-1:0] exp_addr;
    logic [3:0]                   skip;
  } vector_t;

  // --------------------------------------------------------------------
  // DUT signals
  // --------------------------------------------------------------------
  logic                         clk_i = 1'b0;
  logic                         rst_ni;
  logic                         flush_i;
  ex_pkg::fu_op_e               operation_i;
  logic [`EX_XLEN-1:0]          operand_a_i;
  logic [`EX_XLEN-1:0]          operand_b_i;
  logic [`EX_XLEN-1:0]          imm_i;
  logic [`EX_XLEN-1:0]          pc_i;
  logic                         is_compressed_i;
  logic [`EX_TRANS_ID_BITS-1:0] trans_id_i;
  logic                         alu_valid_i;
  logic                         branch_valid_i;
  logic                         csr_valid_i;
  logic                         mult_valid_i;
  logic                         predict_taken_i;
  logic [`EX_XLEN-1:0]          predict_target_i;
  logic                         csr_commit_i;
  logic                         flu_valid_o;
  logic [`EX_XLEN-1:0]          flu_result_o;
  logic [`EX_TRANS_ID_BITS-1:0] flu_trans_id_o;
  logic                         flu_ready_o;
  logic [`EX_CSR_ADDR_BITS-1:0] csr_addr_o;
  logic                         resolve_o;
  logic                         taken_o;
  logic [`EX_XLEN-1:0]          target_o;
  logic                         mispredict_o;

  vector_t vecs[$];
  int      error_count = 0;
  int      cycle_count = 0;
  int      max_cycles  = 20;

  ex_stage ex_stage_inst (.*);

  // Period of 4
  always #2 clk_i = ~clk_i;

  // Run limit, scaled to the vector count once the file is read
  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= max_cycles) begin
      $display("Timeout: %0d cycles passed and the vector run did not finish", cycle_count);
      $display(">>> FAIL");
      $finish;
    end
  end

  // --------------------------------------------------------------------
  // Helpers
  // --------------------------------------------------------------------
  task automatic load_vectors();
    int               fd;
    int               code;
    logic [8*160-1:0] line_buf;
    logic [31:0]      f [NUM_FIELDS];
    fd = $fopen(DATA_FILE, "r");
    if (fd == 0) begin
      $display("Could not open the vector file %s", DATA_FILE);
    end else begin
      while (!$feof(fd)) begin
        line_buf = '0;
        code = $fgets(line_buf, fd);
        if (code > 0) begin
          code = $sscanf(line_buf, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                         f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
                         f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17]);
          // Comment lines start with # and give no fields
          if (code == NUM_FIELDS) begin
            vecs.push_back(vector_t'{f[0][3:0], f[1][4:0], f[2], f[3], f[4], f[5],
                                     f[6][0], f[7][2:0], f[8][0], f[9], f[10][3:0],
                                     f[11][0], f[12], f[13][2:0], f[14][3:0], f[15],
                                     f[16][11:0], f[17][3:0]});
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic drive_vector(input vector_t v);
    alu_valid_i      <= v.strb[0];
    branch_valid_i   <= v.strb[1];
    csr_valid_i      <= v.strb[2];
    mult_valid_i     <= v.strb[3];
    operation_i      <= ex_pkg::fu_op_e'(v.op);
    operand_a_i      <= v.a;
    operand_b_i      <= v.b;
    imm_i            <= v.imm;
    pc_i             <= v.pc;
    is_compressed_i  <= v.comp;
    trans_id_i       <= v.tid;
    predict_taken_i  <= v.ptaken;
    predict_target_i <= v.ptarget;
    csr_commit_i     <= v.ctl[0];
    flush_i          <= v.ctl[1];
  endtask

  task automatic report_mismatch(input int idx, input string name,
                                 input logic [31:0] got, input logic [31:0] exp);
    $display("FAILED %0t: vector %0d, %s is %h, expected %h", $time, idx, name, got, exp);
    error_count++;
  endtask

  // Flags column is ready, resolve, mispredict, taken from the top bit down
  task automatic check_vector(input int idx, input vector_t v);
    assert (flu_valid_o === v.exp_valid)
      else report_mismatch(idx, "flu_valid_o", 32'(flu_valid_o), 32'(v.exp_valid));
    assert (flu_ready_o === v.exp_flags[3])
      else report_mismatch(idx, "flu_ready_o", 32'(flu_ready_o), 32'(v.exp_flags[3]));
    assert (resolve_o === v.exp_flags[2])
      else report_mismatch(idx, "resolve_o", 32'(resolve_o), 32'(v.exp_flags[2]));
    assert (mispredict_o === v.exp_flags[1])
      else report_mismatch(idx, "mispredict_o", 32'(mispredict_o), 32'(v.exp_flags[1]));
    if (!v.skip[0]) begin
      assert (flu_result_o === v.exp_result)
        else report_mismatch(idx, "flu_result_o", flu_result_o, v.exp_result);
    end
    if (!v.skip[1]) begin
      assert (flu_trans_id_o === v.exp_tid)
        else report_mismatch(idx, "flu_trans_id_o", 32'(flu_trans_id_o), 32'(v.exp_tid));
    end
    if (!v.skip[2]) begin
      assert (taken_o === v.exp_flags[0])
        else report_mismatch(idx, "taken_o", 32'(taken_o), 32'(v.exp_flags[0]));
      assert (target_o === v.exp_target)
        else report_mismatch(idx, "target_o", target_o, v.exp_target);
    end
    // Address register has no reset, unknown until the first CSR op
    if (!v.skip[3]) begin
      assert (csr_addr_o === v.exp_addr)
        else report_mismatch(idx, "csr_addr_o", 32'(csr_addr_o), 32'(v.exp_addr));
    end
  endtask

  // --------------------------------------------------------------------
  // Main sequence
  // --------------------------------------------------------------------
  initial begin
    rst_ni <= 1'b0;
    drive_vector('0);
    load_vectors();
    max_cycles = vecs.size() + 20;
    if (vecs.size() == 0) begin
      $display("No test vectors were read from %s", DATA_FILE);
      error_count++;
    end
    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;
    // Drive on the rising edge, sample mid cycle
    foreach (vecs[i]) begin
      @(posedge clk_i);
      drive_vector(vecs[i]);
      @(negedge clk_i);
      check_vector(i, vecs[i]);
    end
    @(posedge clk_i);
    $display("%0d vectors checked, %0d errors", vecs.size(), error_count);
    if (error_count == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule
